// ==== source/msi_pkg.sv ====
package msi_pkg;

	// ==========================================================================
	// sizes
	// ==========================================================================
	localparam int NQUES = 7;                 // priority levels 1..7
	localparam int QDEPTH = 16;               // entries per level queue
	localparam int QPTR_W = $clog2(QDEPTH);   // queue pointer width
	localparam int NVEC = 512;                // vector table words

	// plain vector types
	typedef logic [2:0] pri_t;       // 0 = no priority
	typedef logic [8:0] vecno_t;
	typedef logic [30:0] handler_t;
	typedef logic [9:0] wb_adr_t;    // word address
	typedef logic [31:0] wb_dat_t;
	typedef logic [NQUES-1:0] qmask_t;  // bit 0 = level 1

	// interrupt message as it moves between stages
	typedef struct packed {
		pri_t pri;
		vecno_t vecno;
	} msi_msg_t;

	// one table word, enable in bit 31
	typedef struct packed {
		logic en;
		handler_t handler;
	} vec_entry_t;

	// ==========================================================================
	// register map (word addresses)
	// ==========================================================================
	localparam wb_adr_t REG_CTRL = 10'h000;    // bit 0 global enable
	localparam wb_adr_t REG_THRESH = 10'h001;  // bits 2..0
	localparam wb_adr_t REG_STATUS = 10'h002;  // bit 0 overflow, write 1 clears
	localparam wb_adr_t REG_EMPTY = 10'h003;   // queue empty mask, read only
	// 0x200..0x3ff is the vector table, adr[8:0] is the index

endpackage

// ==== source/msi_intake.sv ====
`timescale 1ns/1ps

module msi_intake import msi_pkg::*; (
	input logic clk,
	input logic rst,
	input logic msg_valid_i,
	input msi_msg_t msg_i,
	output qmask_t wr_o,     // one-hot queue write, at most one bit
	output msi_msg_t msg_o
);

	// level decode, level 0 never matches so it is ignored
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_o <= '0;
		end else begin
			for (int i = 0; i < NQUES; i++)
				wr_o[i] <= msg_valid_i && (msg_i.pri == pri_t'(i + 1));
		end
	end

	// message payload follows the strobe by no cycles
	always_ff @(posedge clk) begin
		msg_o <= msg_i;
	end

endmodule

// ==== source/msi_queue_bank.sv ====
`timescale 1ns/1ps

module msi_queue_bank import msi_pkg::*; (
	input logic clk,
	input logic rst,
	input qmask_t wr_i,
	input msi_msg_t msg_i,
	input qmask_t pop_i,
	output qmask_t empty_o,
	output msi_msg_t [NQUES-1:0] head_o,
	output logic overflow_o
);

	qmask_t drop;   // write hit a full queue

	// ==========================================================================
	// one circular buffer per level
	// ==========================================================================
	for (genvar q = 0; q < NQUES; q++) begin : g_que
		msi_msg_t mem [QDEPTH];
		logic [QPTR_W-1:0] rd_ptr;
		logic [QPTR_W-1:0] wr_ptr;
		logic [QPTR_W:0] count;     // 0..QDEPTH
		logic full;
		logic push;
		logic pop;

		assign full = (count == (QPTR_W + 1)'(QDEPTH));
		assign push = wr_i[q] && !full;         // full queue loses the write
		assign pop = pop_i[q] && !empty_o[q];   // never pop an empty queue
		assign drop[q] = wr_i[q] && full;
		assign empty_o[q] = (count == '0);
		assign head_o[q] = mem[rd_ptr];         // head always visible

		always_ff @(posedge clk) begin
			if (push)
				mem[wr_ptr] <= msg_i;
		end

		always_ff @(posedge clk) begin
			if (rst) begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				count <= '0;
			end else begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;   // wraps at QDEPTH
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				case ({push, pop})
					2'b10: count <= count + 1'b1;
					2'b01: count <= count - 1'b1;
					default: ;                  // both or neither, no change
				endcase
			end
		end
	end

	// single cycle pulse per lost message
	always_ff @(posedge clk) begin
		if (rst)
			overflow_o <= 1'b0;
		else
			overflow_o <= |drop;
	end

endmodule

// ==== source/msi_pri_select.sv ====
`timescale 1ns/1ps

module msi_pri_select import msi_pkg::*; (
	input logic clk,
	input logic rst,
	input qmask_t empty_i,
	input msi_msg_t [NQUES-1:0] head_i,
	input logic global_en_i,
	input pri_t thresh_i,
	input logic busy_i,          // lookup cannot take the candidate
	output qmask_t pop_o,
	output logic cand_valid_o,
	output msi_msg_t cand_o
);

	qmask_t pick;       // one-hot, highest eligible level
	msi_msg_t pick_msg;
	logic found;
	logic free;         // candidate register empty or being taken
	logic load;

	// scan upward, the last hit is the highest level
	always_comb begin
		pick = '0;
		pick_msg = '0;
		found = 1'b0;
		for (int i = 0; i < NQUES; i++) begin
			if (!empty_i[i] && (pri_t'(i + 1) > thresh_i)) begin
				pick = '0;
				pick[i] = 1'b1;
				pick_msg = head_i[i];
				found = 1'b1;
			end
		end
	end

	assign free = !cand_valid_o || !busy_i;
	assign load = global_en_i && found && free;
	assign pop_o = load ? pick : '0;     // pop and load on the same edge

	always_ff @(posedge clk) begin
		if (rst)
			cand_valid_o <= 1'b0;
		else if (load)
			cand_valid_o <= 1'b1;
		else if (!busy_i)
			cand_valid_o <= 1'b0;          // taken, nothing new
	end

	always_ff @(posedge clk) begin
		if (load)
			cand_o <= pick_msg;
	end

endmodule

// ==== source/msi_vector_lookup.sv ====
`timescale 1ns/1ps

module msi_vector_lookup import msi_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cand_valid_i,
	input msi_msg_t cand_i,
	output logic busy_o,
	input logic tbl_we_i,
	input vecno_t tbl_idx_i,
	input vec_entry_t tbl_dat_i,
	input logic irq_ack_i,
	output logic irq_o,
	output handler_t ivect_o,
	output pri_t ipri_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,     // table word on rd_q
		S_HOLD      // irq up until ack
	} state_t;

	state_t state;
	vec_entry_t tbl [NVEC];
	vec_entry_t rd_q;    // registered table word
	pri_t pri_q;
	logic take;

	assign busy_o = (state != S_IDLE);
	assign take = cand_valid_i && (state == S_IDLE);

	// vector table, bus writes and a one cycle read per message
	always_ff @(posedge clk) begin
		if (tbl_we_i)
			tbl[tbl_idx_i] <= tbl_dat_i;
		if (take) begin
			rd_q <= tbl[cand_i.vecno];
			pri_q <= cand_i.pri;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (take) state <= S_READ;
				S_READ: state <= rd_q.en ? S_HOLD : S_IDLE;   // disabled entry dropped
				S_HOLD: if (irq_ack_i) state <= S_IDLE;       // falls on the ack edge
				default: state <= S_IDLE;
			endcase
		end
	end

	// rd_q and pri_q are frozen while busy, so the vector stays stable
	assign irq_o = (state == S_HOLD);
	assign ivect_o = rd_q.handler;
	assign ipri_o = pri_q;

endmodule

// ==== source/msi_regs.sv ====
`timescale 1ns/1ps

module msi_regs import msi_pkg::*; (
	input logic clk,
	input logic rst,
	// wishbone classic slave
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb_adr_t wb_adr_i,
	input wb_dat_t wb_dat_i,
	input logic [3:0] wb_sel_i,
	output logic wb_ack_o,
	output wb_dat_t wb_dat_o,
	// status in
	input logic overflow_i,
	input qmask_t empty_i,
	// control out
	output logic global_en_o,
	output pri_t thresh_o,
	output logic tbl_we_o,
	output vecno_t tbl_idx_o,
	output vec_entry_t tbl_dat_o
);

	logic req;      // new cycle, ack not yet given
	logic wr;       // full-word write, lands on the ack edge
	logic reg_wr;   // write to the register page
	logic ovf;      // sticky overflow

	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wr = req && wb_we_i && (&wb_sel_i);
	assign reg_wr = wr && !wb_adr_i[9];

	// ==========================================================================
	// bus handshake and read mux
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (rst)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= req;    // exactly one cycle per request
	end

	always_ff @(posedge clk) begin
		if (req) begin
			case (wb_adr_i)
				REG_CTRL: wb_dat_o <= wb_dat_t'(global_en_o);
				REG_THRESH: wb_dat_o <= wb_dat_t'(thresh_o);
				REG_STATUS: wb_dat_o <= wb_dat_t'(ovf);
				REG_EMPTY: wb_dat_o <= wb_dat_t'(empty_i);
				default: wb_dat_o <= '0;    // table is write only
			endcase
		end
	end

	// ==========================================================================
	// control and status registers
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			global_en_o <= 1'b0;
			thresh_o <= '0;
			ovf <= 1'b0;
		end else begin
			if (reg_wr && wb_adr_i == REG_CTRL)
				global_en_o <= wb_dat_i[0];
			if (reg_wr && wb_adr_i == REG_THRESH)
				thresh_o <= wb_dat_i[2:0];
			if (reg_wr && wb_adr_i == REG_STATUS && wb_dat_i[0])
				ovf <= 1'b0;          // write 1 to clear
			if (overflow_i)
				ovf <= 1'b1;          // new overflow wins over a clear
		end
	end

	// table port, written by lookup on the same edge as ack
	assign tbl_we_o = wr && wb_adr_i[9];
	assign tbl_idx_o = wb_adr_i[8:0];
	assign tbl_dat_o = vec_entry_t'(wb_dat_i);

endmodule

// ==== source/msi_controller.sv ====
`timescale 1ns/1ps

module msi_controller import msi_pkg::*; (
	input logic clk,
	input logic rst,
	// message port
	input logic msg_valid_i,
	input msi_msg_t msg_i,
	// wishbone
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb_adr_t wb_adr_i,
	input wb_dat_t wb_dat_i,
	input logic [3:0] wb_sel_i,
	output logic wb_ack_o,
	output wb_dat_t wb_dat_o,
	// core side
	input logic irq_ack_i,
	output logic irq_o,
	output handler_t ivect_o,
	output pri_t ipri_o
);

	qmask_t que_wr;                  // intake to queues
	msi_msg_t in_msg;
	qmask_t que_empty;               // queues to selector and regs
	msi_msg_t [NQUES-1:0] que_head;
	qmask_t que_pop;
	logic overflow;
	logic cand_valid;                // selector to lookup
	msi_msg_t cand;
	logic lookup_busy;
	logic global_en;                 // regs to stages
	pri_t thresh;
	logic tbl_we;
	vecno_t tbl_idx;
	vec_entry_t tbl_dat;

	msi_intake i_msi_intake (
		.clk(clk), .rst(rst),
		.msg_valid_i(msg_valid_i), .msg_i(msg_i),
		.wr_o(que_wr), .msg_o(in_msg)
	);

	msi_queue_bank i_msi_queue_bank (
		.clk(clk), .rst(rst),
		.wr_i(que_wr), .msg_i(in_msg), .pop_i(que_pop),
		.empty_o(que_empty), .head_o(que_head), .overflow_o(overflow)
	);

	msi_pri_select i_msi_pri_select (
		.clk(clk), .rst(rst),
		.empty_i(que_empty), .head_i(que_head),
		.global_en_i(global_en), .thresh_i(thresh), .busy_i(lookup_busy),
		.pop_o(que_pop), .cand_valid_o(cand_valid), .cand_o(cand)
	);

	msi_vector_lookup i_msi_vector_lookup (
		.clk(clk), .rst(rst),
		.cand_valid_i(cand_valid), .cand_i(cand), .busy_o(lookup_busy),
		.tbl_we_i(tbl_we), .tbl_idx_i(tbl_idx), .tbl_dat_i(tbl_dat),
		.irq_ack_i(irq_ack_i), .irq_o(irq_o), .ivect_o(ivect_o), .ipri_o(ipri_o)
	);

	msi_regs i_msi_regs (
		.clk(clk), .rst(rst),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
		.overflow_i(overflow), .empty_i(que_empty),
		.global_en_o(global_en), .thresh_o(thresh),
		.tbl_we_o(tbl_we), .tbl_idx_o(tbl_idx), .tbl_dat_o(tbl_dat)
	);

endmodule

// ==== tb/msi_controller_sva.sv ====
`timescale 1ns/1ps

module msi_controller_sva import msi_pkg::*; (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,     // slave ack as seen on the bus
	input logic irq_i,
	input logic irq_ack_i,
	input handler_t ivect_i,
	input pri_t ipri_i,
	input qmask_t empty_i,    // queue empty flags
	input pri_t thresh_i,
	input qmask_t pop_i       // selector pop strobes
);

	qmask_t above_pop;    // levels higher than the popped one
	qmask_t at_thresh;    // levels at or below the threshold

	assign above_pop = ~qmask_t'((pop_i << 1) - 1'b1);
	assign at_thresh = qmask_t'((qmask_t'(1) << thresh_i) - 1'b1);

	// ==========================================================================
	// wishbone handshake
	// ==========================================================================
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o held longer than one cycle");

	ack_after_stb: assert property (@(posedge clk) disable iff (rst)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o without cyc and stb");

	// ==========================================================================
	// irq hold until ack
	// ==========================================================================
	irq_stable: assert property (@(posedge clk) disable iff (rst)
		irq_i && !irq_ack_i |=> irq_i && $stable(ivect_i) && $stable(ipri_i))
		else $error("irq_o or its vector changed before ack");

	irq_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
		irq_i && irq_ack_i |=> !irq_i)
		else $error("irq_o still high after ack");

	// one queue at a time, the highest non-empty one above the threshold
	one_pop: assert property (@(posedge clk) disable iff (rst)
		pop_i != '0 |-> $onehot(pop_i) && (pop_i & (empty_i | at_thresh)) == '0 &&
			(above_pop & ~empty_i) == '0)
		else $error("pop not one-hot or not at the highest eligible level");

endmodule

bind msi_controller msi_controller_sva i_msi_controller_sva (
	.clk(clk), .rst(rst),
	.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o),
	.irq_i(irq_o), .irq_ack_i(irq_ack_i), .ivect_i(ivect_o), .ipri_i(ipri_o),
	.empty_i(que_empty), .thresh_i(thresh),
	.pop_i(que_pop)
);

// ==== tb/msi_controller_tb.sv ====
`timescale 1ns/1ps

module msi_controller_tb import msi_pkg::*; ();

	typedef struct packed {
		pri_t pri;
		vecno_t vecno;
		logic en;            // table enable bit
		handler_t handler;
	} stim_t;

	logic clk = 1'b0;
	logic rst;
	logic msg_valid_i;
	msi_msg_t msg_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	wb_adr_t wb_adr_i;
	wb_dat_t wb_dat_i;
	logic [3:0] wb_sel_i;
	logic wb_ack_o;
	wb_dat_t wb_dat_o;
	logic irq_ack_i;
	logic irq_o;
	handler_t ivect_o;
	pri_t ipri_o;

	int mismatches = 0;
	int failures = 0;        // timeouts and stray irqs
	int pend[$];             // reference model, stim rows in arrival order
	logic en_m = 1'b0;       // model copy of global enable
	pri_t thresh_m = '0;
	logic ovf_m = 1'b0;

	// level, vector, table enable, handler
	stim_t stim_tbl [15] = '{
		'{3'd3, 9'h010, 1'b1, 31'h0000_1010},   // rows 0..7 mixed levels
		'{3'd7, 9'h020, 1'b1, 31'h0000_2020},
		'{3'd5, 9'h030, 1'b0, 31'h0000_3030},   // disabled entry
		'{3'd7, 9'h040, 1'b1, 31'h0000_4040},
		'{3'd1, 9'h050, 1'b1, 31'h0000_5050},
		'{3'd5, 9'h060, 1'b1, 31'h0000_6060},
		'{3'd6, 9'h1ff, 1'b1, 31'h7fff_fffc},
		'{3'd2, 9'h000, 1'b0, 31'h0000_7070},   // disabled entry
		'{3'd4, 9'h101, 1'b1, 31'h0001_0101},   // rows 8..12 threshold
		'{3'd2, 9'h102, 1'b1, 31'h0001_0202},
		'{3'd4, 9'h103, 1'b1, 31'h0001_0303},
		'{3'd1, 9'h104, 1'b1, 31'h0001_0404},
		'{3'd6, 9'h105, 1'b1, 31'h0001_0505},   // above threshold 4
		'{3'd0, 9'h0aa, 1'b1, 31'h0000_0aaa},   // level 0 never queued
		'{3'd3, 9'h1a5, 1'b1, 31'h0abc_d123}    // overflow burst
	};

	msi_controller i_msi_controller (.*);

	always #5 clk = ~clk;

	// ==========================================================================
	// reference model
	// ==========================================================================
	// highest eligible level, first arrival wins within a level
	function automatic int pick_next();
		int best;
		best = -1;
		foreach (pend[k])
			if (stim_tbl[pend[k]].pri > thresh_m &&
				(best < 0 || stim_tbl[pend[k]].pri > stim_tbl[pend[best]].pri))
				best = k;
		return best;
	endfunction

	function automatic qmask_t model_empty();
		qmask_t m;
		m = '1;
		foreach (pend[k])
			m[stim_tbl[pend[k]].pri - 3'd1] = 1'b0;   // bit 0 is level 1
		return m;
	endfunction

	// ==========================================================================
	// bus and message drivers, all called on a falling edge
	// ==========================================================================
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat);
		int n;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_dat_i = dat;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack_o && n < 16);
		if (!wb_ack_o) begin
			failures++;
			$display("no Wishbone ack for address %h", adr);
		end
		wb_cyc_i = 1'b0;    // strobe drops right after ack
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic read_check(input wb_adr_t adr, input wb_dat_t exp);
		bus_access(1'b0, adr, '0);
		if (wb_dat_o !== exp) begin
			mismatches++;
			$display("Mismatch wb_dat_o at %h: got %h expected %h", adr, wb_dat_o, exp);
		end
	endtask

	task automatic send_msg(input int row);
		int cnt;
		msg_valid_i = 1'b1;
		msg_i.pri = stim_tbl[row].pri;
		msg_i.vecno = stim_tbl[row].vecno;
		cnt = 0;
		foreach (pend[k])
			if (stim_tbl[pend[k]].pri == stim_tbl[row].pri)
				cnt++;
		if (stim_tbl[row].pri != 3'd0) begin
			if (cnt < QDEPTH)
				pend.push_back(row);
			else
				ovf_m = 1'b1;     // full queue loses it
		end
		@(negedge clk);
		msg_valid_i = 1'b0;
	endtask

	task automatic ack_irq();
		irq_ack_i = 1'b1;
		@(negedge clk);
		irq_ack_i = 1'b0;
	endtask

	task automatic expect_irq(input int row);
		int n;
		int hold;
		n = 0;
		while (!irq_o && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (!irq_o) begin
			failures++;
			$display("irq_o never came for vector %h", stim_tbl[row].vecno);
		end else begin
			if (ivect_o !== stim_tbl[row].handler) begin
				mismatches++;
				$display("Mismatch ivect_o: got %h expected %h", ivect_o, stim_tbl[row].handler);
			end
			if (ipri_o !== stim_tbl[row].pri) begin
				mismatches++;
				$display("Mismatch ipri_o: got %h expected %h", ipri_o, stim_tbl[row].pri);
			end
			hold = $urandom % 4;     // core takes its time
			repeat (hold) @(negedge clk);
			ack_irq();
		end
	endtask

	// deliver everything the model says is eligible, then watch for strays
	task automatic drain();
		int k;
		int row;
		k = pick_next();
		while (en_m && k >= 0) begin
			row = pend[k];
			pend.delete(k);
			if (stim_tbl[row].en)
				expect_irq(row);      // disabled entries are dropped silently
			k = pick_next();
		end
		repeat (20) begin
			@(negedge clk);
			if (irq_o) begin
				failures++;
				$display("unexpected irq_o with handler %h", ivect_o);
				ack_irq();
			end
		end
	endtask

	// ==========================================================================
	// test sequence
	// ==========================================================================
	initial begin
		void'($urandom(32'hdafc_dab7));
		rst = 1'b1;
		msg_valid_i = 1'b0;
		msg_i = '0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = 4'hf;
		irq_ack_i = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		read_check(REG_EMPTY, wb_dat_t'(model_empty()));
		read_check(REG_STATUS, 32'd0);
		for (int i = 0; i < 15; i++)
			bus_access(1'b1, {1'b1, stim_tbl[i].vecno},
				{stim_tbl[i].en, stim_tbl[i].handler});

		for (int i = 0; i < 8; i++)   // queued while disabled
			send_msg(i);
		bus_access(1'b1, REG_CTRL, 32'd1);
		en_m = 1'b1;
		drain();

		bus_access(1'b1, REG_THRESH, 32'd4);
		thresh_m = 3'd4;
		for (int i = 8; i < 13; i++)
			send_msg(i);
		drain();                      // only level 6 gets out
		read_check(REG_EMPTY, wb_dat_t'(model_empty()));
		bus_access(1'b1, REG_THRESH, 32'd0);
		thresh_m = 3'd0;
		drain();

		bus_access(1'b1, REG_CTRL, 32'd0);
		en_m = 1'b0;
		repeat (QDEPTH + 1) send_msg(14);
		repeat (4) @(negedge clk);    // last write reaches the queue
		read_check(REG_STATUS, wb_dat_t'(ovf_m));
		bus_access(1'b1, REG_CTRL, 32'd1);
		en_m = 1'b1;
		drain();
		bus_access(1'b1, REG_STATUS, 32'd1);
		ovf_m = 1'b0;
		read_check(REG_STATUS, wb_dat_t'(ovf_m));

		repeat (3) send_msg(13);
		drain();
		read_check(REG_EMPTY, wb_dat_t'(model_empty()));
		read_check(REG_CTRL, 32'd1);
		bus_access(1'b1, REG_THRESH, 32'd5);
		read_check(REG_THRESH, 32'd5);
		wb_sel_i = 4'h1;              // byte lane alone writes nothing
		bus_access(1'b1, REG_THRESH, 32'd2);
		wb_sel_i = 4'hf;
		read_check(REG_THRESH, 32'd5);

		$display("mismatches %0d, other failures %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== msi_controller.f ====
source/msi_pkg.sv
source/msi_intake.sv
source/msi_queue_bank.sv
source/msi_pri_select.sv
source/msi_vector_lookup.sv
source/msi_regs.sv
source/msi_controller.sv
tb/msi_controller_sva.sv
tb/msi_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the msi_controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module msi_controller_tb \
	-f msi_controller.f \
	-o msi_controller_sim

./obj_dir/msi_controller_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
